//--- fetch_pkg.sv
package fetch_pkg;

    // reset vector, first fetch after reset
    localparam logic [31:0] BOOT_PC = 32'hbfc0_0000;

    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = 2;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // bit 0 is the slot at the fetch pc
    typedef logic [1:0] slot_mask_t;

    // redirect request from commit, any flag set means redirect
    typedef struct packed {
        logic  exception_valid;
        logic  is_eret;
        logic  branch;
        logic  jump;
        logic  jr;
        word_t pcexception;
        word_t epc;
        word_t pcbranch;
        word_t pcjump;
        word_t pcjr;
    } commit_redirect_t;

    // one instruction to decode
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_slot_t;

    // one outstanding fetch
    typedef struct packed {
        word_t  pc;
        dword_t data;
        logic   filled;
        logic   stale;
    } queue_entry_t;

endpackage

//--- redirect_select.sv
`timescale 1ns/10ps

module redirect_select (
    input  fetch_pkg::commit_redirect_t commit,
    output logic                        redirect_valid,
    output fetch_pkg::word_t            redirect_pc
);

    assign redirect_valid = commit.exception_valid | commit.is_eret | commit.branch
                          | commit.jump | commit.jr;

    // priority order exception, eret, branch, jump, then jr as the default
    always_comb
    begin
        redirect_pc = commit.pcjr;
        if (commit.exception_valid)
        begin
            redirect_pc = commit.pcexception;
        end
        else if (commit.is_eret)
        begin
            redirect_pc = commit.epc;
        end
        else if (commit.branch)
        begin
            redirect_pc = commit.pcbranch;
        end
        else if (commit.jump)
        begin
            redirect_pc = commit.pcjump;
        end
    end

endmodule

//--- pc_request.sv
`timescale 1ns/10ps

module pc_request (
    input  logic             clk,
    input  logic             reset,
    input  logic             redirect_valid,
    input  fetch_pkg::word_t redirect_pc,
    input  logic             full,
    output logic             ibus_req,
    output fetch_pkg::word_t ibus_addr,
    input  logic             ibus_addr_ok,
    output logic             push,
    output fetch_pkg::word_t push_pc
);

    fetch_pkg::word_t pc;
    fetch_pkg::word_t pc_plus4;
    fetch_pkg::word_t pc_plus8;
    fetch_pkg::word_t pc_seq;
    logic             running;
    logic             accept;

    // bus reads whole doublewords
    assign ibus_addr = {pc[31:3], 3'b000};

    // running is low for the cycle after reset, so no request goes out
    assign ibus_req = running & ~full & ~redirect_valid;
    assign accept   = ibus_req & ibus_addr_ok;

    assign push    = accept;
    assign push_pc = pc;

    assign pc_plus4 = pc + 32'd4;
    assign pc_plus8 = pc + 32'd8;

    // odd word only carries one slot
    assign pc_seq = pc[2] ? pc_plus4 : pc_plus8;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            running <= 1'b0;
        end
        else
        begin
            running <= 1'b1;
        end
    end

    // redirect wins over sequencing and drops a request not yet accepted
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            pc <= fetch_pkg::BOOT_PC;
        end
        else if (redirect_valid)
        begin
            pc <= redirect_pc;
        end
        else if (accept)
        begin
            pc <= pc_seq;
        end
    end

endmodule

//--- fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    push,
    input  fetch_pkg::word_t        push_pc,
    input  logic                    ibus_data_ok,
    input  fetch_pkg::dword_t       ibus_data,
    input  logic                    redirect_valid,
    input  logic                    pop,
    output fetch_pkg::queue_entry_t head,
    output logic                    head_valid,
    output logic                    full
);

    fetch_pkg::word_t  pc_mem   [fetch_pkg::QUEUE_DEPTH];
    fetch_pkg::dword_t data_mem [fetch_pkg::QUEUE_DEPTH];

    logic [fetch_pkg::QUEUE_DEPTH-1:0] filled;
    logic [fetch_pkg::QUEUE_DEPTH-1:0] stale;

    logic [fetch_pkg::QUEUE_PTR_W-1:0] wr_ptr;
    logic [fetch_pkg::QUEUE_PTR_W-1:0] fill_ptr;
    logic [fetch_pkg::QUEUE_PTR_W-1:0] rd_ptr;
    logic [fetch_pkg::QUEUE_PTR_W:0]   count;

    assign head_valid = (count != '0);
    assign full       = (count == fetch_pkg::QUEUE_DEPTH);

    always_comb
    begin
        head.pc     = pc_mem[rd_ptr];
        head.data   = data_mem[rd_ptr];
        head.filled = filled[rd_ptr];
        head.stale  = stale[rd_ptr];
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            wr_ptr   <= '0;
            fill_ptr <= '0;
            rd_ptr   <= '0;
            count    <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (ibus_data_ok)
            begin
                fill_ptr <= fill_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push - pop;
        end
    end

    // entries stay occupied after a redirect, late returns land here as stale
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            filled <= '0;
            stale  <= '0;
        end
        else
        begin
            if (redirect_valid)
            begin
                stale <= '1;
            end
            if (ibus_data_ok)
            begin
                filled[fill_ptr] <= 1'b1;
            end
            if (push)
            begin
                filled[wr_ptr] <= 1'b0;
                stale[wr_ptr]  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            pc_mem[wr_ptr] <= push_pc;
        end
        if (ibus_data_ok)
        begin
            data_mem[fill_ptr] <= ibus_data;
        end
    end

endmodule

//--- instr_receive.sv
`timescale 1ns/10ps

module instr_receive (
    input  logic                          clk,
    input  logic                          reset,
    input  fetch_pkg::queue_entry_t       head,
    input  logic                          head_valid,
    output logic                          pop,
    input  logic                          stall,
    output fetch_pkg::fetch_slot_t [1:0]  fetch_data,
    output fetch_pkg::slot_mask_t         fetch_hit,
    output logic                          fetch_valid
);

    fetch_pkg::fetch_slot_t [1:0] slots_next;
    fetch_pkg::slot_mask_t        hit_next;
    logic                         deliver;

    // stale heads drain even under stall
    assign pop     = head_valid & head.filled & (head.stale | ~stall);
    assign deliver = pop & ~head.stale;

    // split the doubleword by bit 2 of the entry pc
    always_comb
    begin
        slots_next[0].pc = head.pc;
        slots_next[1].pc = head.pc + 32'd4;
        if (head.pc[2])
        begin
            slots_next[0].instr = head.data[63:32];
            slots_next[1].instr = '0;
            hit_next            = 2'b01;
        end
        else
        begin
            slots_next[0].instr = head.data[31:0];
            slots_next[1].instr = head.data[63:32];
            hit_next            = 2'b11;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            fetch_valid <= 1'b0;
        end
        else if (!stall)
        begin
            fetch_valid <= deliver;
        end
    end

    // outputs hold while decode is stalled
    always_ff @(posedge clk)
    begin
        if (deliver)
        begin
            fetch_data <= slots_next;
            fetch_hit  <= hit_next;
        end
    end

endmodule

//--- fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  fetch_pkg::commit_redirect_t  commit,
    input  logic                         stall,
    output logic                         ibus_req,
    output fetch_pkg::word_t             ibus_addr,
    input  logic                         ibus_addr_ok,
    input  logic                         ibus_data_ok,
    input  fetch_pkg::dword_t            ibus_data,
    output fetch_pkg::fetch_slot_t [1:0] fetch_data,
    output fetch_pkg::slot_mask_t        fetch_hit,
    output logic                         fetch_valid
);

    logic                    redirect_valid;
    fetch_pkg::word_t        redirect_pc;
    logic                    push;
    fetch_pkg::word_t        push_pc;
    logic                    full;
    logic                    pop;
    logic                    head_valid;
    fetch_pkg::queue_entry_t head;

    redirect_select u_redirect_select (
        .commit         (commit),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    pc_request u_pc_request (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .full           (full),
        .ibus_req       (ibus_req),
        .ibus_addr      (ibus_addr),
        .ibus_addr_ok   (ibus_addr_ok),
        .push           (push),
        .push_pc        (push_pc)
    );

    fetch_queue u_fetch_queue (
        .clk            (clk),
        .reset          (reset),
        .push           (push),
        .push_pc        (push_pc),
        .ibus_data_ok   (ibus_data_ok),
        .ibus_data      (ibus_data),
        .redirect_valid (redirect_valid),
        .pop            (pop),
        .head           (head),
        .head_valid     (head_valid),
        .full           (full)
    );

    instr_receive u_instr_receive (
        .clk         (clk),
        .reset       (reset),
        .head        (head),
        .head_valid  (head_valid),
        .pop         (pop),
        .stall       (stall),
        .fetch_data  (fetch_data),
        .fetch_hit   (fetch_hit),
        .fetch_valid (fetch_valid)
    );

endmodule

//--- ibus_model.sv
`timescale 1ns/10ps

module ibus_model (
    input  logic              clk,
    input  logic              reset,
    input  logic              ibus_req,
    input  fetch_pkg::word_t  ibus_addr,
    output logic              ibus_addr_ok,
    output logic              ibus_data_ok,
    output fetch_pkg::dword_t ibus_data
);

    localparam logic [31:0] WORD_PATTERN = 32'h5a5a_0000;

    fetch_pkg::word_t pending [$];
    fetch_pkg::word_t ret_addr;
    int unsigned      accept_wait;
    int unsigned      return_wait;

    // memory content follows the whole address
    function automatic fetch_pkg::word_t mem_word(input fetch_pkg::word_t addr);
        return addr ^ WORD_PATTERN;
    endfunction

    assign ibus_addr_ok = reset & ibus_req & (accept_wait == 0);

    // bus idle until the first reset edge
    initial
    begin
        accept_wait  = 0;
        return_wait  = 1;
        ibus_data_ok = 1'b0;
        ibus_data    = '0;
    end

    always @(posedge clk)
    begin
        if (!reset)
        begin
            pending.delete();
            accept_wait  <= 0;
            return_wait  <= $urandom_range(4, 1);
            ibus_data_ok <= 1'b0;
            ibus_data    <= '0;
        end
        else
        begin
            ibus_data_ok <= 1'b0;
            // oldest accepted address returns first
            if (pending.size() > 0)
            begin
                if (return_wait <= 1)
                begin
                    ret_addr = pending.pop_front();
                    ibus_data    <= {mem_word(ret_addr + 32'd4), mem_word(ret_addr)};
                    ibus_data_ok <= 1'b1;
                    return_wait  <= $urandom_range(4, 1);
                end
                else
                begin
                    return_wait <= return_wait - 1;
                end
            end
            // a dropped request keeps the remaining wait
            if (ibus_req)
            begin
                if (ibus_addr_ok)
                begin
                    pending.push_back(ibus_addr);
                    accept_wait <= $urandom_range(3, 0);
                end
                else
                begin
                    accept_wait <= accept_wait - 1;
                end
            end
        end
    end

endmodule

//--- fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb;

    localparam int          TESTS        = 6;
    localparam int          TEST_CYCLES  = 400;
    localparam int          CYCLE_LIMIT  = TESTS * TEST_CYCLES * 5 / 3;
    localparam logic [31:0] WORD_PATTERN = 32'h5a5a_0000;

    logic                         clk;
    logic                         reset;
    fetch_pkg::commit_redirect_t  commit;
    logic                         stall;
    logic                         ibus_req;
    fetch_pkg::word_t             ibus_addr;
    logic                         ibus_addr_ok;
    logic                         ibus_data_ok;
    fetch_pkg::dword_t            ibus_data;
    fetch_pkg::fetch_slot_t [1:0] fetch_data;
    fetch_pkg::slot_mask_t        fetch_hit;
    logic                         fetch_valid;

    int                           errors;
    int                           test_errors;
    int                           outputs;
    int                           tests_done;
    int                           cycles;
    logic                         redirecting;
    fetch_pkg::word_t             exp_pc;
    fetch_pkg::word_t             old_pc;
    logic                         old_left;
    logic                         old_probe;
    logic                         reset_q = 1'b1;
    logic                         stall_q;
    logic                         valid_q;
    fetch_pkg::fetch_slot_t [1:0] data_q;
    fetch_pkg::slot_mask_t        hit_q;

    fetch_unit dut (
        .clk          (clk),
        .reset        (reset),
        .commit       (commit),
        .stall        (stall),
        .ibus_req     (ibus_req),
        .ibus_addr    (ibus_addr),
        .ibus_addr_ok (ibus_addr_ok),
        .ibus_data_ok (ibus_data_ok),
        .ibus_data    (ibus_data),
        .fetch_data   (fetch_data),
        .fetch_hit    (fetch_hit),
        .fetch_valid  (fetch_valid)
    );

    ibus_model bus (
        .clk          (clk),
        .reset        (reset),
        .ibus_req     (ibus_req),
        .ibus_addr    (ibus_addr),
        .ibus_addr_ok (ibus_addr_ok),
        .ibus_data_ok (ibus_data_ok),
        .ibus_data    (ibus_data)
    );

    assign redirecting = commit.exception_valid | commit.is_eret | commit.branch
                       | commit.jump | commit.jr;

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic fetch_pkg::word_t next_pc(input fetch_pkg::word_t pc);
        return pc[2] ? pc + 32'd4 : pc + 32'd8;
    endfunction

    // lowest priority first, so the strongest flag overwrites last
    function automatic fetch_pkg::word_t redirect_target(input fetch_pkg::commit_redirect_t c);
        fetch_pkg::word_t target;
        target = c.pcjr;
        if (c.jump)
            target = c.pcjump;
        if (c.branch)
            target = c.pcbranch;
        if (c.is_eret)
            target = c.epc;
        if (c.exception_valid)
            target = c.pcexception;
        return target;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] expected);
        errors++;
        $display("FAILED at %0t ns: %s got %0h, expected %0h", $time, name, got, expected);
    endtask

    task automatic check_output();
        fetch_pkg::word_t pc;
        outputs++;
        // one output may already be registered when the redirect lands
        if (old_left && fetch_data[0].pc == old_pc)
        begin
            pc = old_pc;
        end
        else
        begin
            pc = exp_pc;
            assert (fetch_data[0].pc == pc)
                else report_mismatch("fetch_data[0].pc", fetch_data[0].pc, pc);
            exp_pc = next_pc(exp_pc);
        end
        old_left = 1'b0;
        assert (fetch_data[0].instr == (pc ^ WORD_PATTERN))
            else report_mismatch("fetch_data[0].instr", fetch_data[0].instr, pc ^ WORD_PATTERN);
        assert (fetch_hit == (pc[2] ? 2'b01 : 2'b11))
            else report_mismatch("fetch_hit", fetch_hit, pc[2] ? 2'b01 : 2'b11);
        if (!pc[2])
        begin
            assert (fetch_data[1].pc == pc + 32'd4)
                else report_mismatch("fetch_data[1].pc", fetch_data[1].pc, pc + 32'd4);
            assert (fetch_data[1].instr == ((pc + 32'd4) ^ WORD_PATTERN))
                else report_mismatch("fetch_data[1].instr", fetch_data[1].instr,
                                     (pc + 32'd4) ^ WORD_PATTERN);
        end
    endtask

    always @(posedge clk)
    begin
        assert (reset_q || (!ibus_req && !fetch_valid))
            else report_mismatch("ibus_req/fetch_valid in reset", {ibus_req, fetch_valid}, 2'b00);
        if (reset && reset_q && stall_q)
        begin
            assert (fetch_valid === valid_q)
                else report_mismatch("fetch_valid under stall", fetch_valid, valid_q);
            assert (fetch_data === data_q)
                else report_mismatch("fetch_data under stall", fetch_data, data_q);
            assert (fetch_hit === hit_q)
                else report_mismatch("fetch_hit under stall", fetch_hit, hit_q);
        end
        if (!reset)
        begin
            exp_pc    = fetch_pkg::BOOT_PC;
            old_left  = 1'b0;
            old_probe = 1'b0;
        end
        else
        begin
            assert (!ibus_req || ibus_addr[2:0] == 3'b000)
                else report_mismatch("ibus_addr", ibus_addr, {ibus_addr[31:3], 3'b000});
            if (old_probe)
            begin
                old_left  = fetch_valid;
                old_probe = 1'b0;
            end
            if (fetch_valid && !stall)
                check_output();
            if (redirecting)
            begin
                old_pc    = exp_pc;
                exp_pc    = redirect_target(commit);
                old_left  = 1'b0;
                old_probe = 1'b1;
            end
        end
        reset_q = reset;
        stall_q = stall;
        valid_q = fetch_valid;
        data_q  = fetch_data;
        hit_q   = fetch_hit;
    end

    task automatic wait_outputs(input int count);
        int target;
        target = outputs + count;
        while (outputs < target)
            @(negedge clk);
    endtask

    task automatic apply_redirect(input fetch_pkg::commit_redirect_t c);
        @(negedge clk);
        commit = c;
        @(negedge clk);
        commit = '0;
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %0d %s: %0d outputs checked in total, %0d errors in this test",
                 tests_done, name, outputs, errors - test_errors);
        test_errors = errors;
    endtask

    initial
    begin
        fetch_pkg::commit_redirect_t c;
        void'($urandom(32'h551e_7400));
        errors      = 0;
        test_errors = 0;
        outputs     = 0;
        tests_done  = 0;
        reset       = 1'b0;
        commit      = '0;
        stall       = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        wait_outputs(1);
        finish_test("reset and boot pc");
        wait_outputs(40);
        finish_test("sequential stream");
        c        = '0;
        c.jump   = 1'b1;
        c.pcjump = 32'h0000_1004;
        apply_redirect(c);
        wait_outputs(20);
        finish_test("redirect to odd word");
        c          = '0;
        c.branch   = 1'b1;
        c.pcbranch = 32'h0040_0100;
        apply_redirect(c);
        wait_outputs(20);
        finish_test("redirect with requests in flight");
        repeat (8)
        begin
            c = '0;
            {c.exception_valid, c.is_eret, c.branch, c.jump, c.jr} = $urandom_range(31, 1);
            c.pcexception = $urandom & 32'hffff_fffc;
            c.epc         = $urandom & 32'hffff_fffc;
            c.pcbranch    = $urandom & 32'hffff_fffc;
            c.pcjump      = $urandom & 32'hffff_fffc;
            c.pcjr        = $urandom & 32'hffff_fffc;
            apply_redirect(c);
            wait_outputs(6);
        end
        finish_test("redirect priority");
        repeat (120)
        begin
            @(negedge clk);
            stall = $urandom_range(1, 0);
        end
        @(negedge clk);
        stall = 1'b0;
        wait_outputs(10);
        finish_test("decode stall");
        $display("%0d tests, %0d outputs checked, %0d errors", tests_done, outputs, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("run aborted: tests did not complete within %0d cycles", CYCLE_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- all.f
fetch_pkg.sv
redirect_select.sv
pc_request.sv
fetch_queue.sv
instr_receive.sv
fetch_unit.sv
ibus_model.sv
fetch_tb.sv
